/* source/upsizer_pkg.sv */
// ****************************************
// Upsizer shared definitions
// Widths, SRAM depth and vector types used by
// the narrow to wide memory adapter
// ****************************************

package upsizer_pkg;

  // ****************************************
  // Widths
  // ****************************************

  // Narrow side byte address
  localparam int ADDR_W       = 32;
  // Requester data word
  localparam int NARROW_W     = 32;
  // SRAM data word
  localparam int WIDE_W       = 128;
  localparam int NARROW_BYTES = NARROW_W / 8;
  localparam int WIDE_BYTES   = WIDE_W / 8;
  // Narrow words packed in one wide word
  localparam int LANES        = WIDE_W / NARROW_W;

  // ****************************************
  // SRAM geometry
  // ****************************************

  // 64 wide words, 1 KiB in total
  localparam int MEM_DEPTH    = 64;
  localparam int MEM_IDX_W    = $clog2(MEM_DEPTH);

  // ****************************************
  // Vector types
  // ****************************************

  typedef logic [ADDR_W-1:0]       addr_t;
  typedef logic [NARROW_W-1:0]     narrow_word_t;
  typedef logic [NARROW_BYTES-1:0] narrow_strb_t;
  typedef logic [WIDE_W-1:0]       wide_word_t;
  typedef logic [WIDE_BYTES-1:0]   wide_strb_t;
  // One bit per lane, exactly one set
  typedef logic [LANES-1:0]        lane_onehot_t;
  // Wide word index into the SRAM
  typedef logic [MEM_IDX_W-1:0]    mem_idx_t;

endpackage

/* source/wide_mem_if.sv */
// ****************************************
// Wide SRAM port
// Single port bundle between the lane
// steering stage and the 128-bit SRAM
// ****************************************

interface wide_mem_if;
  import upsizer_pkg::*;

  // Access strobe, one cycle per access
  logic       en;
  // High for write, low for read
  logic       we;
  // Wide word index
  mem_idx_t   idx;
  // Write data, replicated over all lanes
  wide_word_t wdata;
  // Byte strobes, set only in the active lane
  wide_strb_t wstrb;
  // Registered read data, held until next read
  wide_word_t rdata;

  // Request side
  modport master (
    output en,
    output we,
    output idx,
    output wdata,
    output wstrb,
    input  rdata
  );

  // Memory side
  modport slave (
    input  en,
    input  we,
    input  idx,
    input  wdata,
    input  wstrb,
    output rdata
  );

endinterface

/* source/addr_aligner.sv */
// ****************************************
// Address aligner
// Splits a narrow byte address into wide word
// index, one-hot lane select and misalignment
// ****************************************

module addr_aligner (
  input  logic                      valid,
  input  upsizer_pkg::addr_t        addr,
  output upsizer_pkg::mem_idx_t     mem_idx,
  output upsizer_pkg::lane_onehot_t lane_onehot,
  output logic                      misaligned
);
  import upsizer_pkg::*;

  // ****************************************
  // Address fields
  // ****************************************

  // Byte offset inside the narrow word
  logic [$clog2(NARROW_BYTES)-1:0] byte_ofs;
  // Lane number inside the wide word
  logic [$clog2(LANES)-1:0]        lane_idx;

  // Bits 1:0
  assign byte_ofs = addr[$clog2(NARROW_BYTES)-1:0];

  // Bits 3:2
  assign lane_idx = addr[$clog2(NARROW_BYTES) +: $clog2(LANES)];

  // Bits 9:4 give the wide word
  // Anything above the SRAM size is dropped, so addresses wrap
  assign mem_idx = addr[$clog2(WIDE_BYTES) +: MEM_IDX_W];

  // ****************************************
  // Lane decode
  // ****************************************

  // Index to one-hot, lane k owns wide bits 32k+31 down to 32k
  always_comb begin
    lane_onehot = '0;
    for (int k = 0; k < LANES; k++) begin
      lane_onehot[k] = (lane_idx == k);
    end
  end

  // ****************************************
  // Alignment check
  // ****************************************

  // Only whole narrow words are allowed
  // Flag is qualified by the request strobe
  assign misaligned = valid & (byte_ofs != '0);

endmodule

/* source/subword_lane_mux.sv */
// ****************************************
// Sub-word lane steering
// Places narrow writes into one lane of the wide
// SRAM word and picks the lane back on reads
// ****************************************

module subword_lane_mux (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req,
  input  logic                      we,
  input  upsizer_pkg::mem_idx_t     mem_idx,
  input  upsizer_pkg::lane_onehot_t lane_onehot,
  input  logic                      misaligned,
  input  upsizer_pkg::narrow_word_t wdata,
  input  upsizer_pkg::narrow_strb_t wstrb,
  wide_mem_if.master                mem,
  output logic                      rsp_valid,
  output upsizer_pkg::narrow_word_t rdata,
  output logic                      err
);
  import upsizer_pkg::*;

  // SRAM access strobe
  logic         mem_en;
  // Strobes spread over the wide word
  wide_strb_t   strb_wide;

  // Response stage
  logic         rsp_valid_q;
  logic         err_q;
  // Read in flight, enables the lane pick
  logic         rd_q;
  // Lane of the request in the SRAM stage
  lane_onehot_t lane_q;

  // AND-OR result before the read gate
  narrow_word_t rd_pick;

  // ****************************************
  // Request side, same cycle
  // ****************************************

  // Misaligned requests never touch the memory
  assign mem_en = req & ~misaligned;

  assign mem.en  = mem_en;
  assign mem.we  = we;
  assign mem.idx = mem_idx;

  // Same narrow word in every lane
  // The strobes decide which copy lands
  assign mem.wdata = {LANES{wdata}};

  // Strobes only in the selected lane
  always_comb begin
    strb_wide = '0;
    for (int k = 0; k < LANES; k++) begin
      if (lane_onehot[k]) begin
        strb_wide[k*NARROW_BYTES +: NARROW_BYTES] = wstrb;
      end
    end
  end

  assign mem.wstrb = strb_wide;

  // ****************************************
  // Response stage
  // ****************************************

  // One register stage, lines up with the SRAM read register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
      err_q       <= 1'b0;
      rd_q        <= 1'b0;
      lane_q      <= '0;
    end else begin
      // Every request gets exactly one response
      rsp_valid_q <= req;
      err_q       <= req & misaligned;
      // Only aligned reads return data
      rd_q        <= req & ~we & ~misaligned;
      lane_q      <= lane_onehot;
    end
  end

  assign rsp_valid = rsp_valid_q;
  assign err       = err_q;

  // ****************************************
  // Read lane pick
  // ****************************************

  // AND-OR over the lanes, lane_q is one-hot
  always_comb begin
    rd_pick = '0;
    for (int k = 0; k < LANES; k++) begin
      rd_pick |= mem.rdata[k*NARROW_W +: NARROW_W] & {NARROW_W{lane_q[k]}};
    end
  end

  // Writes and errors return zero
  // SRAM rdata holds stale data outside reads
  assign rdata = rd_q ? rd_pick : '0;

endmodule

/* source/wide_sram.sv */
// ****************************************
// Wide SRAM
// 64 x 128-bit single port memory with byte
// write strobes and a registered read port
// ****************************************

module wide_sram (
  input  logic      clk,
  input  logic      rst_n,
  wide_mem_if.slave mem
);
  import upsizer_pkg::*;

  // ****************************************
  // Storage
  // ****************************************

  // Contents are undefined until written
  wide_word_t ram [MEM_DEPTH];

  // Read register
  wide_word_t rdata_q;

  // ****************************************
  // Write port
  // ****************************************

  // Byte merge at the edge where en is sampled
  always_ff @(posedge clk) begin
    if (mem.en && mem.we) begin
      for (int b = 0; b < WIDE_BYTES; b++) begin
        if (mem.wstrb[b]) begin
          ram[mem.idx][b*8 +: 8] <= mem.wdata[b*8 +: 8];
        end
      end
    end
  end

  // ****************************************
  // Read port
  // ****************************************

  // Data one cycle after en
  // Holds the last read while idle or writing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (mem.en && !mem.we) begin
      rdata_q <= ram[mem.idx];
    end
  end

  assign mem.rdata = rdata_q;

endmodule

/* source/upsizer_top.sv */
// ****************************************
// Narrow to wide memory upsizer
// 32-bit request port onto a 128-bit SRAM
// ****************************************

module upsizer_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // Narrow request, one-cycle strobe
  input  logic                      req,
  input  logic                      we,
  input  upsizer_pkg::addr_t        addr,
  input  upsizer_pkg::narrow_word_t wdata,
  input  upsizer_pkg::narrow_strb_t wstrb,
  // Response, one cycle after the request
  output logic                      rsp_valid,
  output upsizer_pkg::narrow_word_t rdata,
  output logic                      err
);

  // Aligner outputs
  upsizer_pkg::mem_idx_t     mem_idx;
  upsizer_pkg::lane_onehot_t lane_onehot;
  logic                      misaligned;

  // Wide port between lane mux and SRAM
  wide_mem_if mem_bus ();

  // ****************************************
  // Address split
  // ****************************************

  addr_aligner u_aligner (
    .valid       (req),
    .addr        (addr),
    .mem_idx     (mem_idx),
    .lane_onehot (lane_onehot),
    .misaligned  (misaligned)
  );

  // ****************************************
  // Lane steering and response
  // ****************************************

  subword_lane_mux u_lane_mux (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .we          (we),
    .mem_idx     (mem_idx),
    .lane_onehot (lane_onehot),
    .misaligned  (misaligned),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .mem         (mem_bus.master),
    .rsp_valid   (rsp_valid),
    .rdata       (rdata),
    .err         (err)
  );

  // ****************************************
  // Memory
  // ****************************************

  wide_sram u_sram (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (mem_bus.slave)
  );

endmodule

/* dv/upsizer_sva.sv */
// ****************************************
// Lane mux assertions
// Response timing and request shape checks
// bound into the lane steering stage
// ****************************************

module upsizer_sva (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      req,
  input upsizer_pkg::lane_onehot_t lane_onehot,
  input logic                      misaligned,
  input logic                      mem_en,
  input logic                      rsp_valid,
  input logic                      err
);
  timeunit 1ns;
  timeprecision 100ps;

  // Number of failed assertions so far
  int assert_fails = 0;

  // One response per request, exactly one cycle later
  rsp_follows_req: assert property (
    @(posedge clk) disable iff (!rst_n) rsp_valid == $past(req)
  ) else begin
    $error("rsp_valid does not follow req by one cycle");
    assert_fails++;
  end

  // Lane select shape while a request is present
  lane_is_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) req |-> $onehot(lane_onehot)
  ) else begin
    $error("lane select is not one-hot during a request");
    assert_fails++;
  end

  // Misaligned requests stay off the SRAM
  no_mem_on_misalign: assert property (
    @(posedge clk) disable iff (!rst_n) !(mem_en && misaligned)
  ) else begin
    $error("memory enable raised for a misaligned request");
    assert_fails++;
  end

  err_has_rsp: assert property (
    @(posedge clk) disable iff (!rst_n) err |-> rsp_valid
  ) else begin
    $error("err high without rsp_valid");
    assert_fails++;
  end

endmodule

bind subword_lane_mux upsizer_sva u_sva (
  .clk         (clk),
  .rst_n       (rst_n),
  .req         (req),
  .lane_onehot (lane_onehot),
  .misaligned  (misaligned),
  .mem_en      (mem_en),
  .rsp_valid   (rsp_valid),
  .err         (err)
);

/* dv/upsizer_tb.sv */
// ****************************************
// Upsizer testbench
// Directed tests against a byte level model
// of the 1 KiB SRAM behind the narrow port
// ****************************************

module upsizer_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import upsizer_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int FILL_WORDS      = 1024 / NARROW_BYTES;
  localparam int RANDOM_REQS     = 200;
  // Reset and directed tests, rounded up
  localparam int DIRECTED_CYCLES = 240;
  localparam int EST_CYCLES      = FILL_WORDS + RANDOM_REQS + DIRECTED_CYCLES;

  logic         clk;
  logic         rst_n;
  logic         req;
  logic         we;
  addr_t        addr;
  narrow_word_t wdata;
  narrow_strb_t wstrb;
  logic         rsp_valid;
  narrow_word_t rdata;
  logic         err;

  // Byte image of the SRAM, indexed by address bits 9:0
  logic [7:0]   ref_mem [1024];

  // Expected response for the request driven one cycle earlier
  logic         exp_valid;
  logic         exp_err;
  narrow_word_t exp_rdata;

  int           check_count;
  int           fail_count;

  upsizer_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .rsp_valid (rsp_valid),
    .rdata     (rdata),
    .err       (err)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Twice the estimated run length
  initial begin
    #(EST_CYCLES * CLK_PERIOD * 2);
    $display("timeout: run did not finish within %0d cycles", EST_CYCLES * 2);
    $display("RESULT: FAIL");
    $finish;
  end

  // ****************************************
  // Reference model
  // ****************************************

  // Little endian, narrow byte j sits at the word address plus j
  function automatic narrow_word_t ref_read(addr_t a);
    narrow_word_t v;
    for (int j = 0; j < NARROW_BYTES; j++) begin
      v[8*j +: 8] = ref_mem[a[9:0] + j];
    end
    return v;
  endfunction

  function automatic void ref_write(addr_t a, narrow_word_t d, narrow_strb_t s);
    for (int j = 0; j < NARROW_BYTES; j++) begin
      if (s[j]) begin
        ref_mem[a[9:0] + j] = d[8*j +: 8];
      end
    end
  endfunction

  // ****************************************
  // Drive and check
  // ****************************************

  task automatic check_response();
    check_count++;
    assert (rsp_valid === exp_valid) else begin
      fail_count++;
      if (exp_valid) begin
        $display("response missing: rsp_valid low one cycle after a request at %0t", $time);
      end else begin
        $display("unexpected rsp_valid with no request outstanding at %0t", $time);
      end
    end
    assert (err === exp_err) else begin
      fail_count++;
      $display("mismatch err: expected %h, got %h at %0t", exp_err, err, $time);
    end
    assert (rdata === exp_rdata) else begin
      fail_count++;
      $display("mismatch rdata: expected %h, got %h at %0t", exp_rdata, rdata, $time);
    end
  endtask

  // One falling edge, checks the due response then drives the next request
  task automatic issue(input logic do_req, input logic do_we, input addr_t a,
                       input narrow_word_t d, input narrow_strb_t s);
    @(negedge clk);
    check_response();
    req   = do_req;
    we    = do_we;
    addr  = a;
    wdata = d;
    wstrb = s;
    exp_valid = do_req;
    exp_err   = do_req && (a[1:0] != 2'b00);
    exp_rdata = '0;
    // Write and error responses carry zero data
    if (do_req && !exp_err) begin
      if (do_we) begin
        ref_write(a, d, s);
      end else begin
        exp_rdata = ref_read(a);
      end
    end
  endtask

  task automatic write_req(input addr_t a, input narrow_word_t d, input narrow_strb_t s);
    issue(1'b1, 1'b1, a, d, s);
  endtask

  task automatic read_req(input addr_t a);
    issue(1'b1, 1'b0, a, '0, '0);
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      issue(1'b0, 1'b0, '0, '0, '0);
    end
  endtask

  task automatic report_test(input string name, input int start_fails);
    $display("%-18s finished, %0d errors", name, fail_count - start_fails);
  endtask

  // ****************************************
  // Tests
  // ****************************************

  task automatic reset_state_test();
    int start;
    start = fail_count;
    for (int i = 0; i < 5; i++) begin
      idle_cycles(1);
      assert (dut.mem_bus.en === 1'b0) else begin
        fail_count++;
        $display("mismatch mem_bus.en: expected 0, got %h", dut.mem_bus.en);
      end
    end
    report_test("reset state", start);
  endtask

  // Four lanes of wide word 0x12, reads interleave with nothing
  task automatic lane_independence_test();
    int start;
    start = fail_count;
    for (int k = 0; k < LANES; k++) begin
      write_req(32'h0000_0120 + 4 * k, 32'h1111_1111 * (k + 1), 4'hF);
    end
    for (int k = 0; k < LANES; k++) begin
      read_req(32'h0000_0120 + 4 * k);
    end
    idle_cycles(2);
    report_test("lane independence", start);
  endtask

  task automatic byte_strobe_test();
    int start;
    start = fail_count;
    write_req(32'h0000_02C8, 32'h0123_4567, 4'hF);
    write_req(32'h0000_02CC, 32'h89AB_CDEF, 4'hF);
    // Partial merges into lanes 2 and 3, empty strobe last
    write_req(32'h0000_02C8, 32'hFFEE_DDCC, 4'b0101);
    write_req(32'h0000_02CC, 32'h7766_5544, 4'b1000);
    write_req(32'h0000_02CC, 32'h3322_1100, 4'b0000);
    read_req(32'h0000_02C8);
    read_req(32'h0000_02CC);
    idle_cycles(2);
    report_test("byte strobes", start);
  endtask

  task automatic misalign_test();
    int start;
    start = fail_count;
    write_req(32'h0000_0040, 32'hCAFE_F00D, 4'hF);
    for (int o = 1; o < NARROW_BYTES; o++) begin
      write_req(32'h0000_0040 + o, 32'hDEAD_BEEF, 4'hF);
      read_req(32'h0000_0040 + o);
    end
    // Memory must still hold the aligned write
    read_req(32'h0000_0040);
    idle_cycles(2);
    report_test("misalignment", start);
  endtask

  task automatic random_traffic_test();
    int    start;
    addr_t a;
    start = fail_count;
    // Fill all words through random upper bits so aliasing shows early
    for (int i = 0; i < FILL_WORDS; i++) begin
      a = $urandom();
      a[9:0] = 10'(i * NARROW_BYTES);
      write_req(a, $urandom(), 4'hF);
    end
    for (int i = 0; i < RANDOM_REQS; i++) begin
      a = $urandom();
      a[1:0] = 2'b00;
      if ($urandom() % 2) begin
        write_req(a, $urandom(), narrow_strb_t'($urandom()));
      end else begin
        read_req(a);
      end
    end
    idle_cycles(2);
    report_test("random traffic", start);
  endtask

  initial begin
    void'($urandom(32'h3386_124d));
    rst_n = 1'b0;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    wstrb = '0;
    check_count = 0;
    fail_count  = 0;
    exp_valid   = 1'b0;
    exp_err     = 1'b0;
    exp_rdata   = '0;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = 8'h00;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_state_test();
    lane_independence_test();
    byte_strobe_test();
    misalign_test();
    random_traffic_test();

    // Bound assertion failures count as errors too
    fail_count += dut.u_lane_mux.u_sva.assert_fails;
    $display("checks %0d, errors %0d", check_count, fail_count);
    if (fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
source/upsizer_pkg.sv
source/wide_mem_if.sv
source/addr_aligner.sv
source/subword_lane_mux.sv
source/wide_sram.sv
source/upsizer_top.sv
dv/upsizer_sva.sv
dv/upsizer_tb.sv
